//--- rtl/maze_pkg.sv
// maze game package with the shared types, the maze geometry, the wall bitmap and lookups.
package maze_pkg;

    // game flow states. only the first stage is played.
    typedef enum logic [1:0] {
        TITLE    = 2'd0,
        STAGE1   = 2'd1,
        SUCCESS1 = 2'd2,
        FAIL     = 2'd3
    } game_state_t;

    // what a single pixel shows on screen.
    typedef enum logic [1:0] {
        LAYER_NONE   = 2'd0,
        LAYER_WALL   = 2'd1,
        LAYER_PLAYER = 2'd2
    } pixel_layer_t;

    // player move directions. up and down change the row, left and right the column.
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_DOWN  = 2'd1,
        DIR_LEFT  = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_t;

    // the maze is a square of 40 by 40 cells, each 5 half-resolution pixels wide.
    localparam int MAZE_CELLS   = 40;
    localparam int CELL_PIX     = 5;
    // top-left corner of the maze in half-resolution pixels.
    localparam int MAZE_X0      = 60;
    localparam int MAZE_Y0      = 30;
    // the sprite sheet is 320 pixels wide, so one row of it is 320 words.
    localparam int PIC_W        = 320;
    // the wall tile starts at this sheet row, and the player tile sits 5 pixels to its right.
    localparam int WALL_TEX_ROW = 120;

    // wall bitmap with row 0 at the top.
    // bit 39 of a row is the leftmost column, and a set bit marks a wall cell.
    // the digits are grouped by ten columns.
    localparam logic [MAZE_CELLS-1:0] MAZE_WALLS [MAZE_CELLS] = '{
        40'b1111111111_1111111111_1111111111_1111111111,
        40'b1000000000_0000000000_1000000000_0000000001,
        40'b1000000000_0000000000_1000000000_0000000001,
        40'b1000000000_0000000000_1000000000_0000000001,
        40'b1000000000_0000000000_1000000000_0000000001,
        40'b1000011111_1111110000_1111111111_1111100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_1111111111_1111111111_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_1111111111_1111111111_1111100001,
        40'b1000010000_0000000000_0000000000_0000000001,
        40'b1000010000_0000000000_0000000000_0000000001,
        40'b0000010000_0000000000_0000000000_0000000000,
        40'b0000010000_0000000000_0000000000_0000000000,
        40'b0000010000_1111111111_1111111111_1111100000,
        40'b0000010000_1000000000_0000000000_0000100000,
        40'b1000010000_1000000000_0000000000_0000100001,
        40'b1000010000_1000000000_0000000000_0000100001,
        40'b1000010000_1000000000_0000000000_0000100001,
        40'b1000010000_1000010000_1100001000_0000100001,
        40'b1000010000_1000010000_1100001000_0000000001,
        40'b1000010000_1000010000_1100001000_0000000001,
        40'b1000010000_1000010000_1100001000_0000000001,
        40'b1000000000_0000010000_1100001000_0000000001,
        40'b1000000000_0000010000_1100001000_0111100001,
        40'b1000000000_0000010000_1100001000_0111100001,
        40'b1000000000_0000010000_1100001000_0111100001,
        40'b1111111111_1111111111_1100001000_0111100001,
        40'b1111111111_1111111111_1100001000_0111100001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1111111111_1111111111_1111111111_1111111111
    };

    // returns 1 for a wall cell.
    // a cell outside the maze also counts as a wall, so a move off the edge is refused.
    function automatic logic maze_is_wall(input logic [5:0] row, input logic [5:0] col);
        logic wall;
        if (row >= MAZE_CELLS || col >= MAZE_CELLS) begin
            wall = 1'b1;
        end else begin
            wall = MAZE_WALLS[row][MAZE_CELLS-1-col];
        end
        return wall;
    endfunction

    // sprite-sheet address of half-resolution pixel (x, y) inside the tile at column tile_x0.
    // tiles are aligned to the 5-pixel grid, so the offset inside a tile is x and y mod 5.
    function automatic logic [16:0] tile_addr(input logic [8:0] x, input logic [8:0] y,
                                              input logic [8:0] tile_x0);
        int col;
        int row;
        col = int'(tile_x0) + int'(x) % CELL_PIX;
        row = WALL_TEX_ROW + int'(y) % CELL_PIX;
        return 17'(row * PIC_W + col);
    endfunction

endpackage

//--- rtl/vga_timing.sv
// vga timing generator for 640x480 at a 25 MHz pixel clock, with sync and frame tick.
`timescale 1ns/1ps

module vga_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic [9:0] h_cnt,
    output logic [9:0] v_cnt,
    output logic       hsync,
    output logic       vsync,
    output logic       video_on,
    output logic       frame_tick
);

    // horizontal line is 800 clocks, with the sync pulse on clocks 656 to 751.
    localparam logic [9:0] H_VISIBLE    = 10'd640;
    localparam logic [9:0] H_SYNC_START = 10'd656;
    localparam logic [9:0] H_SYNC_END   = 10'd751;
    localparam logic [9:0] H_LAST       = 10'd799;
    // a frame is 525 lines, with the sync pulse on lines 490 and 491.
    localparam logic [9:0] V_VISIBLE    = 10'd480;
    localparam logic [9:0] V_SYNC_START = 10'd490;
    localparam logic [9:0] V_SYNC_END   = 10'd491;
    localparam logic [9:0] V_LAST       = 10'd524;

    logic [9:0] h_nxt;
    logic [9:0] v_nxt;

    // next counter values.
    // the line counter steps only when the pixel counter wraps.
    always_comb begin
        h_nxt = (h_cnt == H_LAST) ? 10'd0 : h_cnt + 10'd1;
        v_nxt = v_cnt;
        if (h_cnt == H_LAST) begin
            v_nxt = (v_cnt == V_LAST) ? 10'd0 : v_cnt + 10'd1;
        end
    end

    // the windows are decoded from the next counts.
    // that way the registered flags line up with the counters in the same cycle.
    // after reset the scan sits at (0,0), which is visible and outside both sync pulses.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt      <= 10'd0;
            v_cnt      <= 10'd0;
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            video_on   <= 1'b1;
            frame_tick <= 1'b0;
        end else begin
            h_cnt      <= h_nxt;
            v_cnt      <= v_nxt;
            hsync      <= !(h_nxt >= H_SYNC_START && h_nxt <= H_SYNC_END);
            vsync      <= !(v_nxt >= V_SYNC_START && v_nxt <= V_SYNC_END);
            video_on   <= (h_nxt < H_VISIBLE) && (v_nxt < V_VISIBLE);
            frame_tick <= (v_nxt == V_VISIBLE) && (h_nxt == 10'd0);
        end
    end

    // the pixel counter must wrap at the end of every line.
    a_h_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n) h_cnt <= H_LAST
    );

endmodule

//--- rtl/draw_map.sv
// maze wall layer that flags wall pixels and gives their sprite-sheet address.
`timescale 1ns/1ps

module draw_map import maze_pkg::*; (
    input  game_state_t state,
    input  logic [9:0]  h_cnt,
    input  logic [9:0]  v_cnt,
    output logic        wall_hit,
    output logic [16:0] wall_addr
);

    // the maze square spans 200 half-resolution pixels on each side.
    localparam int MAZE_PIX = MAZE_CELLS * CELL_PIX;

    logic [8:0] x;
    logic [8:0] y;
    logic [8:0] mx;
    logic [8:0] my;
    logic [5:0] cell_row;
    logic [5:0] cell_col;
    logic       in_maze;

    // the game works at half resolution, so the lowest counter bit is dropped.
    assign x = h_cnt[9:1];
    assign y = v_cnt[9:1];

    assign in_maze = (x >= MAZE_X0) && (x < MAZE_X0 + MAZE_PIX) &&
                     (y >= MAZE_Y0) && (y < MAZE_Y0 + MAZE_PIX);

    // offset from the maze corner and the cell under the pixel.
    // the cell index is only meaningful while in_maze is set.
    assign mx       = x - 9'(MAZE_X0);
    assign my       = y - 9'(MAZE_Y0);
    assign cell_col = 6'(mx / CELL_PIX);
    assign cell_row = 6'(my / CELL_PIX);

    // walls are drawn only while the stage is being played.
    // every other pixel reports no hit and address 0.
    always_comb begin
        wall_hit  = 1'b0;
        wall_addr = 17'd0;
        if (state == STAGE1 && in_maze && maze_is_wall(cell_row, cell_col)) begin
            wall_hit  = 1'b1;
            wall_addr = tile_addr(x, y, 9'd0);
        end
    end

endmodule

//--- rtl/player_ctrl.sv
// player position register that applies move pulses and refuses walls and the maze edge.
`timescale 1ns/1ps

module player_ctrl import maze_pkg::*; #(
    parameter int START_ROW = 18,
    parameter int START_COL = 0,
    parameter int GOAL_ROW  = 18,
    parameter int GOAL_COL  = 39
) (
    input  logic        clk,
    input  logic        rst_n,
    input  game_state_t state,
    input  logic        player_reset,
    input  logic        move,
    input  dir_t        dir,
    output logic [5:0]  player_row,
    output logic [5:0]  player_col,
    output logic        at_goal
);

    logic [5:0] tgt_row;
    logic [5:0] tgt_col;
    logic       move_ok;

    // target cell one step away in the requested direction.
    // a step above row 0 or left of column 0 wraps to 63, which the wall lookup rejects.
    always_comb begin
        tgt_row = player_row;
        tgt_col = player_col;
        case (dir)
            DIR_UP:    tgt_row = player_row - 6'd1;
            DIR_DOWN:  tgt_row = player_row + 6'd1;
            DIR_LEFT:  tgt_col = player_col - 6'd1;
            DIR_RIGHT: tgt_col = player_col + 6'd1;
        endcase
    end

    // moves count only during play and only into an open cell.
    assign move_ok = move && (state == STAGE1) && !maze_is_wall(tgt_row, tgt_col);

    // the reset pulse from the game FSM wins over a move in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            player_row <= 6'(START_ROW);
            player_col <= 6'(START_COL);
        end else if (player_reset) begin
            player_row <= 6'(START_ROW);
            player_col <= 6'(START_COL);
        end else if (move_ok) begin
            player_row <= tgt_row;
            player_col <= tgt_col;
        end
    end

    // combinational so the FSM sees the goal on the edge right after the move lands.
    assign at_goal = (player_row == 6'(GOAL_ROW)) && (player_col == 6'(GOAL_COL));

    // the player can never stand on a wall cell, whatever sequence of moves arrives.
    a_player_open: assert property (
        @(posedge clk) disable iff (!rst_n) !maze_is_wall(player_row, player_col)
    );

endmodule

//--- rtl/game_fsm.sv
// game flow FSM through title, stage, success and fail, with the stage frame timer.
`timescale 1ns/1ps

module game_fsm import maze_pkg::*; #(
    parameter int STAGE_FRAMES = 1800
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        btn_start,
    input  logic        frame_tick,
    input  logic        at_goal,
    output game_state_t state,
    output logic        player_reset
);

    localparam int CNT_W = $clog2(STAGE_FRAMES + 1);

    game_state_t      state_nxt;
    logic [CNT_W-1:0] frame_cnt;
    logic             start_play;
    logic             win;
    logic             timeout;

    assign start_play = (state == TITLE) && btn_start;

    // in the first stage cycle the player still holds its old cell.
    // that may be the goal from the last game, so the goal is ignored until the reset lands.
    assign win = (state == STAGE1) && at_goal && !player_reset;

    // the stage is lost on the tick that brings the count up to STAGE_FRAMES.
    assign timeout = (state == STAGE1) && frame_tick &&
                     (frame_cnt == CNT_W'(STAGE_FRAMES - 1));

    // a win beats a timeout in the same cycle.
    always_comb begin
        state_nxt = state;
        case (state)
            TITLE: begin
                if (btn_start) begin
                    state_nxt = STAGE1;
                end
            end
            STAGE1: begin
                if (win) begin
                    state_nxt = SUCCESS1;
                end else if (timeout) begin
                    state_nxt = FAIL;
                end
            end
            SUCCESS1, FAIL: begin
                if (btn_start) begin
                    state_nxt = TITLE;
                end
            end
        endcase
    end

    // player_reset is high for exactly the first cycle of STAGE1.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= TITLE;
            player_reset <= 1'b0;
        end else begin
            state        <= state_nxt;
            player_reset <= start_play;
        end
    end

    // the timer clears on entry to the stage and counts frame ticks only during play.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (start_play) begin
            frame_cnt <= '0;
        end else if (state == STAGE1 && frame_tick) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // the stage is left before the timer can run past its limit.
    a_timer_limit: assert property (
        @(posedge clk) disable iff (!rst_n) frame_cnt <= CNT_W'(STAGE_FRAMES)
    );

endmodule

//--- rtl/pixel_compose.sv
// pixel compositor that lays the player over the maze and registers video aligned with sync.
`timescale 1ns/1ps

module pixel_compose import maze_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [9:0]   h_cnt,
    input  logic [9:0]   v_cnt,
    input  logic         video_on,
    input  logic         hsync,
    input  logic         vsync,
    input  logic         wall_hit,
    input  logic [16:0]  wall_addr,
    input  logic [5:0]   player_row,
    input  logic [5:0]   player_col,
    output pixel_layer_t pixel_layer,
    output logic [16:0]  pixel_addr,
    output logic [8:0]   pixel_x,
    output logic [8:0]   pixel_y,
    output logic         video_out,
    output logic         hsync_out,
    output logic         vsync_out
);

    logic [8:0]   x;
    logic [8:0]   y;
    logic [8:0]   px0;
    logic [8:0]   py0;
    logic         player_hit;
    pixel_layer_t layer_nxt;
    logic [16:0]  addr_nxt;

    assign x = h_cnt[9:1];
    assign y = v_cnt[9:1];

    // corner of the player square in half-resolution pixels.
    assign px0 = 9'(MAZE_X0) + 9'(player_col * CELL_PIX);
    assign py0 = 9'(MAZE_Y0) + 9'(player_row * CELL_PIX);

    assign player_hit = (x >= px0) && (x < px0 + 9'(CELL_PIX)) &&
                        (y >= py0) && (y < py0 + 9'(CELL_PIX));

    // the player covers any wall under it.
    // the player tile lies one tile to the right of the wall tile on the sheet.
    always_comb begin
        layer_nxt = LAYER_NONE;
        addr_nxt  = 17'd0;
        if (video_on) begin
            if (player_hit) begin
                layer_nxt = LAYER_PLAYER;
                addr_nxt  = tile_addr(x, y, 9'(CELL_PIX));
            end else if (wall_hit) begin
                layer_nxt = LAYER_WALL;
                addr_nxt  = wall_addr;
            end
        end
    end

    // layer and sync state, one clock behind the counters.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_layer <= LAYER_NONE;
            video_out   <= 1'b0;
            hsync_out   <= 1'b1;
            vsync_out   <= 1'b1;
        end else begin
            pixel_layer <= layer_nxt;
            video_out   <= video_on;
            hsync_out   <= hsync;
            vsync_out   <= vsync;
        end
    end

    // address and coordinates travel in step with the layer.
    always_ff @(posedge clk) begin
        pixel_addr <= addr_nxt;
        pixel_x    <= x;
        pixel_y    <= y;
    end

endmodule

//--- rtl/maze_game_top.sv
// maze game top level that joins timing, game flow, player, map and pixel output.
`timescale 1ns/1ps

module maze_game_top import maze_pkg::*; #(
    parameter int STAGE_FRAMES = 1800,
    parameter int START_ROW    = 18,
    parameter int START_COL    = 0,
    parameter int GOAL_ROW     = 18,
    parameter int GOAL_COL     = 39
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         btn_start,
    input  logic         move,
    input  dir_t         dir,
    output pixel_layer_t pixel_layer,
    output logic [16:0]  pixel_addr,
    output logic [8:0]   pixel_x,
    output logic [8:0]   pixel_y,
    output logic         video_out,
    output logic         hsync_out,
    output logic         vsync_out,
    output game_state_t  game_state,
    output logic [5:0]   player_row,
    output logic [5:0]   player_col
);

    logic [9:0]  h_cnt;
    logic [9:0]  v_cnt;
    logic        hsync;
    logic        vsync;
    logic        video_on;
    logic        frame_tick;
    logic        player_reset;
    logic        at_goal;
    logic        wall_hit;
    logic [16:0] wall_addr;

    vga_timing u_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .h_cnt      (h_cnt),
        .v_cnt      (v_cnt),
        .hsync      (hsync),
        .vsync      (vsync),
        .video_on   (video_on),
        .frame_tick (frame_tick)
    );

    game_fsm #(
        .STAGE_FRAMES (STAGE_FRAMES)
    ) u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .btn_start    (btn_start),
        .frame_tick   (frame_tick),
        .at_goal      (at_goal),
        .state        (game_state),
        .player_reset (player_reset)
    );

    player_ctrl #(
        .START_ROW (START_ROW),
        .START_COL (START_COL),
        .GOAL_ROW  (GOAL_ROW),
        .GOAL_COL  (GOAL_COL)
    ) u_player (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (game_state),
        .player_reset (player_reset),
        .move         (move),
        .dir          (dir),
        .player_row   (player_row),
        .player_col   (player_col),
        .at_goal      (at_goal)
    );

    // the wall layer is combinational and works straight off the scan counters.
    draw_map u_map (
        .state     (game_state),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .wall_hit  (wall_hit),
        .wall_addr (wall_addr)
    );

    pixel_compose u_compose (
        .clk         (clk),
        .rst_n       (rst_n),
        .h_cnt       (h_cnt),
        .v_cnt       (v_cnt),
        .video_on    (video_on),
        .hsync       (hsync),
        .vsync       (vsync),
        .wall_hit    (wall_hit),
        .wall_addr   (wall_addr),
        .player_row  (player_row),
        .player_col  (player_col),
        .pixel_layer (pixel_layer),
        .pixel_addr  (pixel_addr),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .video_out   (video_out),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out)
    );

endmodule

//--- verif/maze_game_tb.sv
// testbench for the maze game top level with directed tests of game flow, moves and pixels.
`timescale 1ns/1ps

module maze_game_tb import maze_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int FRAME_CYCLES = 420000;
    // six frames of scan, with a margin for the short tests around them.
    localparam int WATCHDOG_NS  = (6 * FRAME_CYCLES + 20000) * CLK_PERIOD;
    // the checked band is the player's row of cells, half-resolution lines 120 to 124.
    localparam int BAND_Y0      = 120;
    localparam int BAND_Y1      = 124;
    // ten scan lines of 640 visible pixels fall inside the band.
    localparam int BAND_SAMPLES = 6400;

    logic         clk;
    logic         rst_n;
    logic         btn_start;
    logic         move;
    dir_t         dir;
    pixel_layer_t pixel_layer;
    logic [16:0]  pixel_addr;
    logic [8:0]   pixel_x;
    logic [8:0]   pixel_y;
    logic         video_out;
    logic         hsync_out;
    logic         vsync_out;
    game_state_t  game_state;
    logic [5:0]   player_row;
    logic [5:0]   player_col;

    int error_count;
    int check_count;
    int tests_run;
    int tests_failed;
    int test_first_error;

    // player cell as the testbench expects it from the moves it has made.
    int model_row;
    int model_col;

    // a short stage and a goal three cells to the right of the start keep the run brief.
    maze_game_top #(
        .STAGE_FRAMES (2),
        .START_ROW    (18),
        .START_COL    (0),
        .GOAL_ROW     (18),
        .GOAL_COL     (3)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .btn_start   (btn_start),
        .move        (move),
        .dir         (dir),
        .pixel_layer (pixel_layer),
        .pixel_addr  (pixel_addr),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .video_out   (video_out),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .game_state  (game_state),
        .player_row  (player_row),
        .player_col  (player_col)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic check_state(input string name, input game_state_t got,
                               input game_state_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_layer(input string name, input pixel_layer_t got,
                               input pixel_layer_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
        end
    endtask

    // sync bits, cell indices and sheet addresses all fit a 17-bit word.
    task automatic check_value(input string name, input logic [16:0] got,
                               input logic [16:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic start_test();
        tests_run++;
        test_first_error = error_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - test_first_error;
        if (errs == 0) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    // expected layer and sheet address of one half-resolution pixel during play.
    task automatic predict_pixel(input int x, input int y, input int prow, input int pcol,
                                 output pixel_layer_t layer, output logic [16:0] addr);
        int px0;
        int py0;
        px0   = MAZE_X0 + pcol * CELL_PIX;
        py0   = MAZE_Y0 + prow * CELL_PIX;
        layer = LAYER_NONE;
        addr  = 17'd0;
        if (x >= px0 && x < px0 + CELL_PIX && y >= py0 && y < py0 + CELL_PIX) begin
            layer = LAYER_PLAYER;
            addr  = 17'((x % 5 + 5) + (y % 5 + WALL_TEX_ROW) * PIC_W);
        end else if (x >= 60 && x < 260 && y >= 30 && y < 230 &&
                     maze_is_wall(6'((y - 30) / 5), 6'((x - 60) / 5))) begin
            layer = LAYER_WALL;
            addr  = 17'((x % 5) + (y % 5 + WALL_TEX_ROW) * PIC_W);
        end
    endtask

    // a move lands only on an open cell inside the 40 by 40 maze.
    task automatic predict_move(input int row, input int col, input dir_t d,
                                output int exp_row, output int exp_col);
        int tr;
        int tc;
        tr = row;
        tc = col;
        case (d)
            DIR_UP:    tr = row - 1;
            DIR_DOWN:  tr = row + 1;
            DIR_LEFT:  tc = col - 1;
            DIR_RIGHT: tc = col + 1;
        endcase
        exp_row = row;
        exp_col = col;
        if (tr >= 0 && tr < MAZE_CELLS && tc >= 0 && tc < MAZE_CELLS &&
            !maze_is_wall(6'(tr), 6'(tc))) begin
            exp_row = tr;
            exp_col = tc;
        end
    endtask

    // one-cycle start pulse.
    // the state has changed by the falling edge that follows.
    task automatic press_start();
        @(posedge clk);
        btn_start <= 1'b1;
        @(posedge clk);
        btn_start <= 1'b0;
        @(negedge clk);
    endtask

    // one-cycle move pulse, with the new position checked once it has been registered.
    task automatic step_player(input dir_t d);
        int exp_row;
        int exp_col;
        predict_move(model_row, model_col, d, exp_row, exp_col);
        @(posedge clk);
        move <= 1'b1;
        dir  <= d;
        @(posedge clk);
        move <= 1'b0;
        @(negedge clk);
        check_value("player_row", player_row, 17'(exp_row));
        check_value("player_col", player_col, 17'(exp_col));
        model_row = exp_row;
        model_col = exp_col;
    endtask

    task automatic wait_for_state(input game_state_t exp, input int limit);
        int cycles;
        cycles = 0;
        while (game_state !== exp && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (game_state !== exp) begin
            report_error($sformatf("state did not reach %s within %0d cycles",
                                   exp.name(), limit));
        end
    endtask

    task automatic test_after_reset();
        start_test();
        check_state("game_state", game_state, TITLE);
        check_value("hsync_out", hsync_out, 17'd1);
        check_value("vsync_out", vsync_out, 17'd1);
        check_value("video_out", video_out, 17'd0);
        check_layer("pixel_layer", pixel_layer, LAYER_NONE);
        check_value("player_row", player_row, 17'd18);
        check_value("player_col", player_col, 17'd0);
        end_test("after reset");
    endtask

    task automatic test_start_stage();
        start_test();
        press_start();
        check_state("game_state", game_state, STAGE1);
        // the player reset lands one edge after the state change.
        @(posedge clk);
        @(negedge clk);
        check_value("player_row", player_row, 17'd18);
        check_value("player_col", player_col, 17'd0);
        model_row = 18;
        model_col = 0;
        end_test("start stage");
    endtask

    task automatic test_moves();
        start_test();
        // off the left edge, into the wall above, then into the open cell to the right.
        step_player(DIR_LEFT);
        step_player(DIR_UP);
        step_player(DIR_RIGHT);
        check_state("game_state", game_state, STAGE1);
        end_test("moves");
    endtask

    task automatic test_pixel_band();
        int           cycles;
        int           samples;
        int           n_wall;
        int           n_player;
        int           n_none;
        int           line_idx;
        int           vis_idx;
        bit           armed;
        bit           done;
        bit           in_band;
        bit           prev_vis;
        pixel_layer_t exp_layer;
        logic [16:0]  exp_addr;
        start_test();
        cycles   = 0;
        samples  = 0;
        n_wall   = 0;
        n_player = 0;
        n_none   = 0;
        line_idx = -1;
        vis_idx  = 0;
        armed    = 1'b0;
        done     = 1'b0;
        prev_vis = 1'b0;
        // checking starts only at the top of the band, so the whole band is seen.
        while (!done && cycles < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
            in_band = (pixel_y >= BAND_Y0) && (pixel_y <= BAND_Y1);
            if (!in_band) begin
                done  = armed && (samples > 0);
                armed = 1'b1;
            end else if (armed && video_out) begin
                // a visible run is one scan line, and two scan lines share one half line.
                if (!prev_vis) begin
                    line_idx++;
                    vis_idx = 0;
                end
                check_value("pixel_x", pixel_x, 17'(vis_idx / 2));
                check_value("pixel_y", pixel_y, 17'(BAND_Y0 + line_idx / 2));
                vis_idx++;
                predict_pixel(pixel_x, pixel_y, model_row, model_col, exp_layer, exp_addr);
                check_layer("pixel_layer", pixel_layer, exp_layer);
                check_value("pixel_addr", pixel_addr, exp_addr);
                samples++;
                n_wall   += (exp_layer == LAYER_WALL);
                n_player += (exp_layer == LAYER_PLAYER);
                n_none   += (exp_layer == LAYER_NONE);
            end else if (armed) begin
                // blanking inside the band shows nothing.
                check_layer("pixel_layer", pixel_layer, LAYER_NONE);
                check_value("pixel_addr", pixel_addr, 17'd0);
            end
            prev_vis = video_out;
        end
        if (samples != BAND_SAMPLES) begin
            report_error($sformatf("pixel band gave %0d visible samples instead of %0d",
                                   samples, BAND_SAMPLES));
        end
        if (n_wall == 0 || n_player == 0 || n_none == 0) begin
            report_error("pixel band did not cover wall, player and background pixels");
        end
        end_test("pixel band");
    endtask

    task automatic test_win();
        start_test();
        step_player(DIR_RIGHT);
        step_player(DIR_RIGHT);
        wait_for_state(SUCCESS1, 4);
        check_state("game_state", game_state, SUCCESS1);
        press_start();
        check_state("game_state", game_state, TITLE);
        end_test("win");
    endtask

    task automatic test_timeout();
        int falls;
        int cycles;
        bit prev_vsync;
        start_test();
        press_start();
        check_state("game_state", game_state, STAGE1);
        @(posedge clk);
        @(negedge clk);
        check_value("player_row", player_row, 17'd18);
        check_value("player_col", player_col, 17'd0);
        model_row  = 18;
        model_col  = 0;
        falls      = 0;
        cycles     = 0;
        prev_vsync = vsync_out;
        while (game_state == STAGE1 && falls < 3 && cycles < 3 * FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (prev_vsync && !vsync_out) begin
                falls++;
            end
            prev_vsync = vsync_out;
        end
        check_state("game_state", game_state, FAIL);
        // two frame ticks span a full frame, so one vsync pulse lies between them.
        if (falls >= 3) begin
            report_error("stage timer did not expire by the second frame tick");
        end else if (falls < 1) begin
            report_error("stage timer expired before a full frame had passed");
        end
        end_test("timeout");
    endtask

    initial begin
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_row    = 18;
        model_col    = 0;
        rst_n        = 1'b0;
        btn_start    = 1'b0;
        move         = 1'b0;
        dir          = DIR_UP;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // the flops have not left reset yet at this falling edge.
        @(negedge clk);
        test_after_reset();
        test_start_stage();
        test_moves();
        test_pixel_band();
        test_win();
        test_timeout();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish within six frames");
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- maze_game.f
rtl/maze_pkg.sv
rtl/vga_timing.sv
rtl/draw_map.sv
rtl/player_ctrl.sv
rtl/game_fsm.sv
rtl/pixel_compose.sv
rtl/maze_game_top.sv
verif/maze_game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the maze game testbench with Verilator and run it.
# Exit status is 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f maze_game.f --top-module maze_game_tb -o maze_game_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/maze_game_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
